// File: riscv_pkg.sv
package riscv_pkg;

    // processor-wide widths
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [DATA_WIDTH-1:0] instr_t;

    // axi read address channel fields
    typedef logic [7:0] axi_len_t;
    typedef logic [2:0] axi_size_t;
    typedef logic [1:0] axi_burst_t;

    // arsize code for 4-byte beats
    localparam axi_size_t AXI_SIZE_4B = 3'b010;

    // incrementing burst
    localparam axi_burst_t AXI_BURST_INCR = 2'b01;

endpackage

// File: icache_pkg.sv
package icache_pkg;

    // cache geometry
    localparam int ICACHE_WAY_NUM = 2;
    localparam int ICACHE_SET_NUM = 16;
    localparam int ICACHE_LINE_SIZE = 32;

    // address split, low bits first
    localparam int ICACHE_BYTE_OFFSET = 2;
    localparam int ICACHE_LINE_OFFSET = 3;
    localparam int ICACHE_INDEX_WIDTH = 4;
    localparam int ICACHE_TAG_WIDTH = riscv_pkg::ADDR_WIDTH - ICACHE_INDEX_WIDTH
                                      - ICACHE_LINE_OFFSET - ICACHE_BYTE_OFFSET;

    // 4-byte beats per line refill
    localparam int ICACHE_BEATS = ICACHE_LINE_SIZE / 4;

    typedef logic [ICACHE_TAG_WIDTH-1:0] tag_t;
    typedef logic [ICACHE_INDEX_WIDTH-1:0] index_t;
    typedef logic [ICACHE_LINE_OFFSET-1:0] word_off_t;
    typedef logic [ICACHE_LINE_SIZE*8-1:0] line_t;

    // register bus
    typedef logic [1:0] reg_addr_t;
    typedef logic [31:0] reg_data_t;

    localparam reg_addr_t REG_CTRL = 2'd0;
    localparam reg_addr_t REG_HIT_CNT = 2'd1;
    localparam reg_addr_t REG_MISS_CNT = 2'd2;

endpackage

// File: icache_core.sv
module icache_core (
    input  logic               clk,
    input  logic               rst_n,
    input  riscv_pkg::addr_t   pc_addr,
    input  logic               pc_valid,
    input  logic               resp_valid,
    input  icache_pkg::line_t  resp_data,
    input  logic               cache_enable,
    input  logic               invalidate,
    output riscv_pkg::instr_t  instruction,
    output logic               instr_valid,
    output logic               req_valid,
    output riscv_pkg::addr_t   req_addr,
    output logic               hit_event,
    output logic               miss_event
);
    import riscv_pkg::*;
    import icache_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        REFILL
    } state_t;

    state_t state_q, state_d;

    // latched fetch address and its fields
    addr_t     addr_q;
    tag_t      tag;
    index_t    index;
    word_off_t word_off;

    // storage, one valid vector per way
    logic [ICACHE_SET_NUM-1:0] valid_q [ICACHE_WAY_NUM];
    tag_t                      tag_mem [ICACHE_WAY_NUM][ICACHE_SET_NUM];
    line_t                     data_mem [ICACHE_WAY_NUM][ICACHE_SET_NUM];
    logic [ICACHE_SET_NUM-1:0] lru_q;

    logic [ICACHE_WAY_NUM-1:0] hit;
    logic                      hit_any;
    line_t                     hit_line;
    logic                      fill;
    logic                      inv_pending_q;
    logic                      do_inv;

    assign tag      = addr_q[ADDR_WIDTH-1 -: ICACHE_TAG_WIDTH];
    assign index    = addr_q[ICACHE_BYTE_OFFSET+ICACHE_LINE_OFFSET +: ICACHE_INDEX_WIDTH];
    assign word_off = addr_q[ICACHE_BYTE_OFFSET +: ICACHE_LINE_OFFSET];

    always_ff @(posedge clk) begin
        if (state_q == IDLE && pc_valid) begin
            addr_q <= pc_addr;
        end
    end

    // tag compare across ways
    always_comb begin
        hit_line = '0;
        for (int w = 0; w < ICACHE_WAY_NUM; w++) begin
            hit[w] = valid_q[w][index] && (tag_mem[w][index] == tag);
            if (hit[w]) begin
                hit_line = data_mem[w][index];
            end
        end
    end

    // a disabled cache never hits
    assign hit_any = cache_enable && (|hit);

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:    if (pc_valid) state_d = LOOKUP;
            LOOKUP:  state_d = hit_any ? IDLE : REFILL;
            REFILL:  if (resp_valid) state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign instr_valid = (state_q == LOOKUP && hit_any) || (state_q == REFILL && resp_valid);
    assign instruction = (state_q == LOOKUP) ? hit_line[word_off*DATA_WIDTH +: DATA_WIDTH]
                                             : resp_data[word_off*DATA_WIDTH +: DATA_WIDTH];

    assign req_valid  = (state_q == LOOKUP) && !hit_any;
    assign req_addr   = addr_t'({tag, index}) << (ICACHE_BYTE_OFFSET + ICACHE_LINE_OFFSET);
    assign hit_event  = (state_q == LOOKUP) && cache_enable && hit_any;
    assign miss_event = (state_q == LOOKUP) && cache_enable && !hit_any;

    // install only while enabled
    assign fill = (state_q == REFILL) && resp_valid && cache_enable;

    // invalidate waits for idle
    assign do_inv = (state_q == IDLE) && (inv_pending_q || invalidate);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            inv_pending_q <= 1'b0;
        end else if (do_inv) begin
            inv_pending_q <= 1'b0;
        end else if (invalidate) begin
            inv_pending_q <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int w = 0; w < ICACHE_WAY_NUM; w++) begin
                valid_q[w] <= '0;
            end
            lru_q <= '0;
        end else if (do_inv) begin
            for (int w = 0; w < ICACHE_WAY_NUM; w++) begin
                valid_q[w] <= '0;
            end
            lru_q <= '0;
        end else if (fill) begin
            valid_q[lru_q[index]][index] <= 1'b1;
            lru_q[index] <= ~lru_q[index];
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            tag_mem[lru_q[index]][index]  <= tag;
            data_mem[lru_q[index]][index] <= resp_data;
        end
    end

    // requester keeps one fetch in flight
    a_pc_valid_idle: assert property (@(posedge clk) disable iff (!rst_n)
        pc_valid |-> state_q == IDLE);

    a_hit_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        state_q == LOOKUP |-> $onehot0(hit));

    a_resp_in_refill: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid |-> state_q == REFILL);

endmodule

// File: axi_read_master.sv
module axi_read_master (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  req_valid,
    input  riscv_pkg::addr_t      req_addr,
    input  logic                  arready,
    input  logic                  rvalid,
    input  riscv_pkg::instr_t     rdata,
    input  logic                  rlast,
    output logic                  resp_valid,
    output icache_pkg::line_t     resp_data,
    output logic                  arvalid,
    output riscv_pkg::addr_t      araddr,
    output riscv_pkg::axi_len_t   arlen,
    output riscv_pkg::axi_size_t  arsize,
    output riscv_pkg::axi_burst_t arburst,
    output logic                  rready
);
    import riscv_pkg::*;
    import icache_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        AR,
        R
    } state_t;

    state_t    state_q, state_d;
    addr_t     addr_q;
    word_off_t beat_q;
    line_t     line_q;
    logic      beat;

    assign beat = (state_q == R) && rvalid && rready;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:    if (req_valid) state_d = AR;
            AR:      if (arready) state_d = R;
            R:       if (beat && rlast) state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= IDLE;
            beat_q     <= '0;
            resp_valid <= 1'b0;
        end else begin
            state_q    <= state_d;
            resp_valid <= beat && rlast;
            if (state_q == IDLE) begin
                beat_q <= '0;
            end else if (beat) begin
                beat_q <= beat_q + 1'b1;
            end
        end
    end

    // request address and line buffer
    always_ff @(posedge clk) begin
        if (state_q == IDLE && req_valid) begin
            addr_q <= req_addr;
        end
        if (beat) begin
            line_q[beat_q*DATA_WIDTH +: DATA_WIDTH] <= rdata;
        end
    end

    assign resp_data = line_q;

    assign arvalid = (state_q == AR);
    assign araddr  = addr_q;
    assign arlen   = axi_len_t'(ICACHE_BEATS - 1);
    assign arsize  = AXI_SIZE_4B;
    assign arburst = AXI_BURST_INCR;
    assign rready  = (state_q == R);

    a_ar_stable: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid && !arready |=> arvalid && $stable(araddr));

    // slave must end the burst on the eighth beat
    a_rlast_beat: assert property (@(posedge clk) disable iff (!rst_n)
        beat |-> rlast == (beat_q == word_off_t'(ICACHE_BEATS - 1)));

endmodule

// File: icache_ctrl_regs.sv
module icache_ctrl_regs (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  reg_we,
    input  icache_pkg::reg_addr_t reg_addr,
    input  icache_pkg::reg_data_t reg_wdata,
    input  logic                  hit_event,
    input  logic                  miss_event,
    output icache_pkg::reg_data_t reg_rdata,
    output logic                  cache_enable,
    output logic                  invalidate
);
    import icache_pkg::*;

    logic      enable_q;
    reg_data_t hit_cnt_q;
    reg_data_t miss_cnt_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            enable_q   <= 1'b1;
            invalidate <= 1'b0;
        end else begin
            // bit 1 is write-one, pulses for one cycle
            invalidate <= reg_we && (reg_addr == REG_CTRL) && reg_wdata[1];
            if (reg_we && reg_addr == REG_CTRL) begin
                enable_q <= reg_wdata[0];
            end
        end
    end

    // saturating counters, any write clears
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hit_cnt_q  <= '0;
            miss_cnt_q <= '0;
        end else begin
            if (reg_we && reg_addr == REG_HIT_CNT) begin
                hit_cnt_q <= '0;
            end else if (hit_event && hit_cnt_q != '1) begin
                hit_cnt_q <= hit_cnt_q + 1'b1;
            end
            if (reg_we && reg_addr == REG_MISS_CNT) begin
                miss_cnt_q <= '0;
            end else if (miss_event && miss_cnt_q != '1) begin
                miss_cnt_q <= miss_cnt_q + 1'b1;
            end
        end
    end

    always_comb begin
        case (reg_addr)
            REG_CTRL:     reg_rdata = reg_data_t'(enable_q);
            REG_HIT_CNT:  reg_rdata = hit_cnt_q;
            REG_MISS_CNT: reg_rdata = miss_cnt_q;
            default:      reg_rdata = '0;
        endcase
    end

    assign cache_enable = enable_q;

endmodule

// File: icache_top.sv
module icache_top (
    input  logic                  clk,
    input  logic                  rst_n,
    // fetch side
    input  riscv_pkg::addr_t      pc_addr,
    input  logic                  pc_valid,
    output riscv_pkg::instr_t     instruction,
    output logic                  instr_valid,
    // axi read address
    output logic                  arvalid,
    output riscv_pkg::addr_t      araddr,
    output riscv_pkg::axi_len_t   arlen,
    output riscv_pkg::axi_size_t  arsize,
    output riscv_pkg::axi_burst_t arburst,
    input  logic                  arready,
    // axi read data
    input  logic                  rvalid,
    input  riscv_pkg::instr_t     rdata,
    input  logic                  rlast,
    output logic                  rready,
    // register bus
    input  logic                  reg_we,
    input  icache_pkg::reg_addr_t reg_addr,
    input  icache_pkg::reg_data_t reg_wdata,
    output icache_pkg::reg_data_t reg_rdata
);
    import riscv_pkg::*;
    import icache_pkg::*;

    logic  req_valid;
    addr_t req_addr;
    logic  resp_valid;
    line_t resp_data;
    logic  cache_enable;
    logic  invalidate;
    logic  hit_event;
    logic  miss_event;

    icache_core i_core (
        .clk          (clk),
        .rst_n        (rst_n),
        .pc_addr      (pc_addr),
        .pc_valid     (pc_valid),
        .resp_valid   (resp_valid),
        .resp_data    (resp_data),
        .cache_enable (cache_enable),
        .invalidate   (invalidate),
        .instruction  (instruction),
        .instr_valid  (instr_valid),
        .req_valid    (req_valid),
        .req_addr     (req_addr),
        .hit_event    (hit_event),
        .miss_event   (miss_event)
    );

    axi_read_master i_refill (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req_addr   (req_addr),
        .arready    (arready),
        .rvalid     (rvalid),
        .rdata      (rdata),
        .rlast      (rlast),
        .resp_valid (resp_valid),
        .resp_data  (resp_data),
        .arvalid    (arvalid),
        .araddr     (araddr),
        .arlen      (arlen),
        .arsize     (arsize),
        .arburst    (arburst),
        .rready     (rready)
    );

    icache_ctrl_regs i_regs (
        .clk          (clk),
        .rst_n        (rst_n),
        .reg_we       (reg_we),
        .reg_addr     (reg_addr),
        .reg_wdata    (reg_wdata),
        .hit_event    (hit_event),
        .miss_event   (miss_event),
        .reg_rdata    (reg_rdata),
        .cache_enable (cache_enable),
        .invalidate   (invalidate)
    );

endmodule

// File: tb_icache.sv
module tb_icache;
    import riscv_pkg::*;
    import icache_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int RESET_CYCLES = 16;
    localparam int FETCH_LIMIT = 200;
    localparam int CYCLES_PER_FETCH = 40;
    localparam int WATCHDOG_TIME = FETCH_LIMIT * CYCLES_PER_FETCH * CLK_PERIOD;

    logic       clk;
    logic       rst_n;
    addr_t      pc_addr;
    logic       pc_valid;
    instr_t     instruction;
    logic       instr_valid;
    logic       arvalid;
    addr_t      araddr;
    axi_len_t   arlen;
    axi_size_t  arsize;
    axi_burst_t arburst;
    logic       arready;
    logic       rvalid;
    instr_t     rdata;
    logic       rlast;
    logic       rready;
    logic       reg_we;
    reg_addr_t  reg_addr;
    reg_data_t  reg_wdata;
    reg_data_t  reg_rdata;

    // bursts seen by the memory model
    int         ar_count;
    addr_t      last_araddr;
    axi_len_t   last_arlen;
    axi_size_t  last_arsize;
    axi_burst_t last_arburst;

    // reference cache state
    logic ref_valid [ICACHE_WAY_NUM][ICACHE_SET_NUM];
    tag_t ref_tag [ICACHE_WAY_NUM][ICACHE_SET_NUM];
    logic ref_lru [ICACHE_SET_NUM];
    int   ref_hits;
    int   ref_misses;
    bit   ref_enabled;

    icache_top i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .pc_addr     (pc_addr),
        .pc_valid    (pc_valid),
        .instruction (instruction),
        .instr_valid (instr_valid),
        .arvalid     (arvalid),
        .araddr      (araddr),
        .arlen       (arlen),
        .arsize      (arsize),
        .arburst     (arburst),
        .arready     (arready),
        .rvalid      (rvalid),
        .rdata       (rdata),
        .rlast       (rlast),
        .rready      (rready),
        .reg_we      (reg_we),
        .reg_addr    (reg_addr),
        .reg_wdata   (reg_wdata),
        .reg_rdata   (reg_rdata)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("timeout: the tests did not finish within %0d time units", WATCHDOG_TIME);
        $display("SIMULATION FAILED");
        $fatal(1);
    end

    // all driving happens just after the rising edge
    task automatic step_cycle();
        @(posedge clk);
        #2;
    endtask

    function automatic instr_t mem_word(addr_t a);
        return a ^ 32'h5a5a_0000;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("error: %s expected %h actual %h", name, expected, actual);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    endtask

    // axi slave with random stalls on arready and rvalid
    initial begin : axi_slave_model
        addr_t base;
        int    stall;
        arready  = 1'b0;
        rvalid   = 1'b0;
        rdata    = '0;
        rlast    = 1'b0;
        ar_count = 0;
        forever begin
            step_cycle();
            if (arvalid) begin
                stall = $urandom_range(0, 3);
                repeat (stall) step_cycle();
                arready      = 1'b1;
                base         = araddr;
                last_araddr  = araddr;
                last_arlen   = arlen;
                last_arsize  = arsize;
                last_arburst = arburst;
                ar_count++;
                step_cycle();
                arready = 1'b0;
                for (int b = 0; b < ICACHE_BEATS; b++) begin
                    stall = $urandom_range(0, 2);
                    repeat (stall) step_cycle();
                    rvalid = 1'b1;
                    rdata  = mem_word(base + addr_t'(b * 4));
                    rlast  = (b == ICACHE_BEATS - 1);
                    // the beat must be taken on the coming edge
                    check_value("rready on beat", 32'd1, 32'(rready));
                    step_cycle();
                    rvalid = 1'b0;
                    rlast  = 1'b0;
                end
            end
        end
    end

    task automatic ref_clear();
        for (int w = 0; w < ICACHE_WAY_NUM; w++) begin
            for (int s = 0; s < ICACHE_SET_NUM; s++) begin
                ref_valid[w][s] = 1'b0;
            end
        end
        for (int s = 0; s < ICACHE_SET_NUM; s++) begin
            ref_lru[s] = 1'b0;
        end
    endtask

    // predicts hit or miss and installs on a miss
    function automatic bit ref_access(addr_t a);
        tag_t   t;
        index_t i;
        bit     hit;
        logic   way;
        t   = a[ADDR_WIDTH-1 -: ICACHE_TAG_WIDTH];
        i   = a[ICACHE_BYTE_OFFSET+ICACHE_LINE_OFFSET +: ICACHE_INDEX_WIDTH];
        hit = 1'b0;
        if (!ref_enabled) begin
            return 1'b0;
        end
        for (int w = 0; w < ICACHE_WAY_NUM; w++) begin
            if (ref_valid[w][i] && ref_tag[w][i] == t) begin
                hit = 1'b1;
            end
        end
        if (hit) begin
            ref_hits++;
        end else begin
            ref_misses++;
            way             = ref_lru[i];
            ref_valid[way][i] = 1'b1;
            ref_tag[way][i]   = t;
            ref_lru[i]        = ~ref_lru[i];
        end
        return hit;
    endfunction

    task automatic reg_write(input reg_addr_t a, input reg_data_t d);
        reg_we    = 1'b1;
        reg_addr  = a;
        reg_wdata = d;
        step_cycle();
        reg_we = 1'b0;
    endtask

    task automatic check_reg(input string name, input reg_addr_t a, input reg_data_t expected);
        reg_addr = a;
        #1;
        check_value(name, expected, reg_rdata);
    endtask

    // one fetch checked for data, latency and burst count
    task automatic fetch_check(input string name, input addr_t a);
        int lat;
        int ar_before;
        bit exp_hit;
        ar_before = ar_count;
        exp_hit   = ref_access(a);
        pc_addr   = a;
        pc_valid  = 1'b1;
        step_cycle();
        pc_valid = 1'b0;
        lat      = 1;
        while (!instr_valid) begin
            step_cycle();
            lat++;
        end
        check_value(name, mem_word(a & ~addr_t'(3)), instruction);
        check_value({name, " hit latency"}, 32'(exp_hit), 32'(lat == 1));
        check_value({name, " bursts"}, ar_before + (exp_hit ? 0 : 1), ar_count);
        step_cycle();
    endtask

    task automatic test_reset_regs();
        check_reg("reset ctrl", REG_CTRL, 32'd1);
        check_reg("reset hit count", REG_HIT_CNT, 32'd0);
        check_reg("reset miss count", REG_MISS_CNT, 32'd0);
    endtask

    task automatic test_miss_then_hit();
        addr_t base;
        base = 32'h0000_1040;
        fetch_check("first miss", base + 32'h8);
        check_value("araddr aligned", base, last_araddr);
        check_value("arlen", 32'd7, 32'(last_arlen));
        check_value("arsize", 32'(AXI_SIZE_4B), 32'(last_arsize));
        check_value("arburst", 32'(AXI_BURST_INCR), 32'(last_arburst));
        for (int w = 0; w < ICACHE_BEATS; w++) begin
            if (w != 2) begin
                fetch_check($sformatf("line hit word %0d", w), base + addr_t'(w * 4));
            end
        end
        check_reg("line hit count", REG_HIT_CNT, 32'd7);
        check_reg("line miss count", REG_MISS_CNT, 32'd1);
    endtask

    task automatic test_lru_replace();
        int ar_before;
        ar_before = ar_count;
        // three tags in set 5
        fetch_check("lru fill a", 32'h0001_00a0);
        fetch_check("lru fill b", 32'h0002_00a0);
        fetch_check("lru evict a", 32'h0003_00a0);
        fetch_check("lru keep b", 32'h0002_00a4);
        fetch_check("lru refetch a", 32'h0001_00a8);
        check_value("lru bursts", ar_before + 4, ar_count);
        check_reg("lru hit count", REG_HIT_CNT, 32'd8);
        check_reg("lru miss count", REG_MISS_CNT, 32'd5);
    endtask

    task automatic test_invalidate();
        fetch_check("before invalidate", 32'h0000_1048);
        // bit 1 invalidates and bit 0 keeps the cache on
        reg_write(REG_CTRL, 32'h3);
        ref_clear();
        fetch_check("after invalidate", 32'h0000_1048);
        check_reg("invalidate miss count", REG_MISS_CNT, 32'(ref_misses));
        check_reg("invalidate ctrl", REG_CTRL, 32'd1);
    endtask

    task automatic test_disable();
        int ar_before;
        reg_write(REG_CTRL, 32'h0);
        ref_enabled = 1'b0;
        ar_before   = ar_count;
        for (int n = 0; n < 3; n++) begin
            fetch_check($sformatf("disabled fetch %0d", n), 32'h0000_2c04);
        end
        check_value("disabled bursts", ar_before + 3, ar_count);
        check_reg("disabled hit count", REG_HIT_CNT, 32'(ref_hits));
        check_reg("disabled miss count", REG_MISS_CNT, 32'(ref_misses));
        reg_write(REG_CTRL, 32'h1);
        ref_enabled = 1'b1;
        fetch_check("re-enabled miss", 32'h0000_2c04);
        check_reg("re-enabled miss count", REG_MISS_CNT, 32'(ref_misses));
    endtask

    task automatic test_backpressure_random();
        int unsigned line;
        int unsigned word;
        addr_t       a;
        for (int n = 0; n < 100; n++) begin
            line = $urandom_range(0, 63);
            word = $urandom_range(0, 7);
            a    = addr_t'((line << 5) | (word << 2));
            fetch_check($sformatf("random fetch %0d", n), a);
        end
        check_reg("random hit count", REG_HIT_CNT, 32'(ref_hits));
        check_reg("random miss count", REG_MISS_CNT, 32'(ref_misses));
    endtask

    initial begin
        void'($urandom(32'h6c9e));
        rst_n       = 1'b0;
        pc_addr     = '0;
        pc_valid    = 1'b0;
        reg_we      = 1'b0;
        reg_addr    = REG_CTRL;
        reg_wdata   = '0;
        ref_hits    = 0;
        ref_misses  = 0;
        ref_enabled = 1'b1;
        ref_clear();
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_n = 1'b1;
        step_cycle();
        test_reset_regs();
        test_miss_then_hit();
        test_lru_replace();
        test_invalidate();
        test_disable();
        test_backpressure_random();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: files.f
riscv_pkg.sv
icache_pkg.sv
icache_core.sv
axi_read_master.sv
icache_ctrl_regs.sv
icache_top.sv
tb_icache.sv

// File: Makefile
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing
TOP        := tb_icache
FILELIST   := files.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := SIMULATION PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
